//--- common/fb_pkg.sv
//----------------------------------------------------------------------
// frame buffer pixel path shared definitions
//   geometry localparams for planes, columns and rows
//   video SRAM address word with raw and field views
//----------------------------------------------------------------------

package fb_pkg;

	//------------------------------------------------------------------
	// geometry
	//------------------------------------------------------------------

	// four bit planes give a 4-bit colour index
	localparam int plane_count = 4;

	// byte column counter, bit 0 is dropped from the address
	localparam int column_w = 6;

	// scan row input, bit 0 selects the line pair half
	localparam int row_w = 9;

	// line start value, chosen so the column wraps to zero at the left edge
	localparam logic [column_w-1:0] column_reload = 6'd52;

	// pixel enables between border_raw and borderx,
	// equal to the shift register latency
	localparam int border_delay_len = 5;

	//------------------------------------------------------------------
	// video SRAM address
	//------------------------------------------------------------------

	// field layout, msb first
	typedef struct packed {
		logic       page;
		logic [1:0] plane;
		logic [4:0] col;
		logic [7:0] row;
	} fb_addr_fields_t;

	// same 16 bits seen as a bus or as fields
	typedef union packed {
		logic [15:0]     raw;
		fb_addr_fields_t fields;
	} fb_addr_u;

endpackage

//--- fetch/plane_fetch.sv
//----------------------------------------------------------------------
// bit plane fetch sequencer
//   phase and byte column counters
//   video SRAM address generation
//   per-plane load strobes and raw border flag
//----------------------------------------------------------------------

module plane_fetch (
	input  logic                        clk24,
	input  logic                        arst_n,
	input  logic                        video_slice,
	input  logic                        hsync,
	input  logic [fb_pkg::row_w-1:0]    fb_row,
	output fb_pkg::fb_addr_u            addr,
	output logic [fb_pkg::plane_count-1:0] load,
	output logic                        border_raw
);

	// phase within one column fetch, two clocks per plane
	logic [2:0] ax;

	// byte column, bit 0 is not part of the address
	logic [fb_pkg::column_w-1:0] column;

	// last phase of the column
	logic phase_wrap;

	// hsync low on the odd row half starts a new line
	logic line_start;

	// column wraps through zero here
	logic column_zero;

	// load strobe for the next cycle
	logic [fb_pkg::plane_count-1:0] load_next;

	assign phase_wrap  = (ax == 3'd7);
	assign line_start  = !hsync && fb_row[0];
	assign column_zero = (column == '0);

	// plane k is addressed while ax is 2k and 2k+1,
	// the strobe fires one clock after ax equals 2k
	always_comb begin
		for (int k = 0; k < fb_pkg::plane_count; k++) begin
			load_next[k] = (ax == 3'(2 * k));
		end
	end

	//------------------------------------------------------------------
	// phase counter, address and load strobes
	//------------------------------------------------------------------
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			ax       <= 3'd0;
			addr.raw <= 16'h0000;
			load     <= '0;
		end else if (video_slice) begin
			ax <= ax + 3'd1;
			// address uses the column before any advance this clock
			addr.fields.page  <= 1'b1;
			addr.fields.plane <= ax[2:1];
			addr.fields.col   <= column[fb_pkg::column_w-1:1];
			addr.fields.row   <= fb_row[fb_pkg::row_w-1:1];
			load <= load_next;
		end else begin
			// stalled, no strobes and counters hold
			load <= '0;
		end
	end

	//------------------------------------------------------------------
	// column counter and border flag
	//------------------------------------------------------------------
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			column     <= '0;
			border_raw <= 1'b0;
		end else if (video_slice && phase_wrap) begin
			if (line_start) begin
				column     <= fb_pkg::column_reload;
				border_raw <= 1'b1;
			end else begin
				column <= column + 1'b1;
			end
			// toggle wins over the line start set when both happen
			if (column_zero) begin
				border_raw <= !border_raw;
			end
		end
	end

endmodule

//--- shifter/plane_shifter.sv
//----------------------------------------------------------------------
// one bit plane buffer
//   pair of 8-bit shift registers in ping-pong
//   pipe_abx picks the shifting register, the other takes loads
//----------------------------------------------------------------------

module plane_shifter (
	input  logic       clk24,
	input  logic       arst_n,
	input  logic       ce_pixel,
	input  logic       pipe_abx,
	input  logic       load,
	input  logic [7:0] din,
	output logic       bit_out
);

	// register a shifts while pipe_abx is low
	logic [7:0] shreg_a;

	// register b shifts while pipe_abx is high
	logic [7:0] shreg_b;

	// per-register enables
	logic load_a;
	logic load_b;
	logic shift_a;
	logic shift_b;

	//------------------------------------------------------------------
	// enable decode
	//------------------------------------------------------------------

	// loads go to the idle register
	assign load_a = load && pipe_abx;
	assign load_b = load && !pipe_abx;

	// shifting goes to the selected register
	assign shift_a = ce_pixel && !pipe_abx;
	assign shift_b = ce_pixel && pipe_abx;

	// selected msb is the current pixel bit
	assign bit_out = pipe_abx ? shreg_b[7] : shreg_a[7];

	//------------------------------------------------------------------
	// registers
	//------------------------------------------------------------------
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			shreg_a <= 8'h00;
		end else if (load_a) begin
			shreg_a <= din;
		end else if (shift_a) begin
			// left shift, zero fill
			shreg_a <= {shreg_a[6:0], 1'b0};
		end
	end

	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			shreg_b <= 8'h00;
		end else if (load_b) begin
			shreg_b <= din;
		end else if (shift_b) begin
			shreg_b <= {shreg_b[6:0], 1'b0};
		end
	end

endmodule

//--- design/pixel_out.sv
//----------------------------------------------------------------------
// pixel output stage
//   border flag delay line on pixel enables
//   colour index assembly and border colour override
//----------------------------------------------------------------------

module pixel_out (
	input  logic       clk24,
	input  logic       arst_n,
	input  logic       ce_pixel,
	input  logic       border_raw,
	input  logic [3:0] plane_bits,
	input  logic [3:0] border_color,
	output logic [3:0] coloridx,
	output logic       borderx
);

	// border flag pipeline, newest at bit 0
	logic [fb_pkg::border_delay_len-1:0] border_line;

	//------------------------------------------------------------------
	// delay line
	//------------------------------------------------------------------

	// one stage per pixel, lines the flag up with the shifter output
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			border_line <= '0;
		end else if (ce_pixel) begin
			border_line <= {border_line[fb_pkg::border_delay_len-2:0], border_raw};
		end
	end

	// oldest stage
	assign borderx = border_line[fb_pkg::border_delay_len-1];

	//------------------------------------------------------------------
	// colour index
	//------------------------------------------------------------------

	// plane 0 already sits at bit 3 of plane_bits
	// border colour replaces the pixel while in the border
	assign coloridx = borderx ? border_color : plane_bits;

endmodule

//--- design/fb_top.sv
//----------------------------------------------------------------------
// frame buffer pixel path top level
//   fetch sequencer, four plane shifters, pixel output stage
//----------------------------------------------------------------------

module fb_top (
	input  logic        clk24,
	input  logic        arst_n,
	input  logic        ce_pixel,
	input  logic        video_slice,
	input  logic        pipe_abx,
	input  logic        hsync,
	input  logic [8:0]  fb_row,
	input  logic [3:0]  border_color,
	input  logic [7:0]  sram_dq,
	output logic [15:0] sram_addr,
	output logic [3:0]  coloridx,
	output logic        borderx
);

	// fetch address in both views
	fb_pkg::fb_addr_u fetch_addr;

	// per-plane load strobes
	logic [3:0] load;

	// border flag before the pixel delay line
	logic border_raw;

	// plane bits, plane 0 at the msb
	logic [3:0] plane_bits;

	// SRAM bus takes the raw view
	assign sram_addr = fetch_addr.raw;

	//------------------------------------------------------------------
	// producer
	//------------------------------------------------------------------
	plane_fetch fetch0 (
		.clk24       (clk24),
		.arst_n      (arst_n),
		.video_slice (video_slice),
		.hsync       (hsync),
		.fb_row      (fb_row),
		.addr        (fetch_addr),
		.load        (load),
		.border_raw  (border_raw)
	);

	//------------------------------------------------------------------
	// buffers, one per plane
	//------------------------------------------------------------------
	plane_shifter shift0 (
		.clk24 (clk24), .arst_n (arst_n), .ce_pixel (ce_pixel), .pipe_abx (pipe_abx),
		.load (load[0]), .din (sram_dq), .bit_out (plane_bits[3])
	);
	plane_shifter shift1 (
		.clk24 (clk24), .arst_n (arst_n), .ce_pixel (ce_pixel), .pipe_abx (pipe_abx),
		.load (load[1]), .din (sram_dq), .bit_out (plane_bits[2])
	);
	plane_shifter shift2 (
		.clk24 (clk24), .arst_n (arst_n), .ce_pixel (ce_pixel), .pipe_abx (pipe_abx),
		.load (load[2]), .din (sram_dq), .bit_out (plane_bits[1])
	);
	plane_shifter shift3 (
		.clk24 (clk24), .arst_n (arst_n), .ce_pixel (ce_pixel), .pipe_abx (pipe_abx),
		.load (load[3]), .din (sram_dq), .bit_out (plane_bits[0])
	);

	//------------------------------------------------------------------
	// consumer
	//------------------------------------------------------------------
	pixel_out out0 (
		.clk24        (clk24),
		.arst_n       (arst_n),
		.ce_pixel     (ce_pixel),
		.border_raw   (border_raw),
		.plane_bits   (plane_bits),
		.border_color (border_color),
		.coloridx     (coloridx),
		.borderx      (borderx)
	);

endmodule

//--- testbench/tb_sram_model.sv
//----------------------------------------------------------------------
// video SRAM model for the pixel path testbench
//   asynchronous read, data byte is a hash of the address
//----------------------------------------------------------------------

module tb_sram_model (
	input  logic [15:0] addr,
	output logic [7:0]  dq
);

	// full hash word of the current address
	logic [31:0] hash;

	// one xorshift round
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// seeded with a fixed constant so every run sees the same memory
	// two rounds so page and plane bits also reach the low byte
	assign hash = xorshift32(xorshift32(32'haa63_301d ^ {16'h0000, addr}));

	// read data follows the address with no clock
	assign dq = hash[7:0];

endmodule

//--- testbench/tb_fb.sv
//----------------------------------------------------------------------
// pixel path testbench
//   clock, reset and a stimulus table applied in a loop
//   cycle reference model of fetch, plane shifters and border delay
//   per-cycle output checks, border wait and summary
//----------------------------------------------------------------------

module tb_fb;

	// DUT ports
	logic        clk24;
	logic        arst_n;
	logic        ce_pixel;
	logic        video_slice;
	logic        pipe_abx;
	logic        hsync;
	logic [8:0]  fb_row;
	logic [3:0]  border_color;
	logic [7:0]  sram_dq;
	logic [15:0] sram_addr;
	logic [3:0]  coloridx;
	logic        borderx;

	// one stimulus word per step, msb first
	// video_slice ce_pixel pipe_abx hsync fb_row[8:0] border_color[3:0] cycles[11:0]
	logic [28:0] steps [0:5];

	// reference model state
	fb_pkg::fb_addr_u                    m_addr;
	logic [2:0]                          m_ax;
	logic [5:0]                          m_col;
	logic                                m_braw;
	logic [3:0]                          m_load;
	logic [7:0]                          m_a [0:3];
	logic [7:0]                          m_b [0:3];
	logic [fb_pkg::border_delay_len-1:0] m_bline;

	// observed address in the field view
	fb_pkg::fb_addr_u got_addr;

	int n_errors;
	int n_checks;

	fb_top dut0 (
		.clk24 (clk24), .arst_n (arst_n), .ce_pixel (ce_pixel),
		.video_slice (video_slice), .pipe_abx (pipe_abx), .hsync (hsync),
		.fb_row (fb_row), .border_color (border_color), .sram_dq (sram_dq),
		.sram_addr (sram_addr), .coloridx (coloridx), .borderx (borderx)
	);

	tb_sram_model sram0 (
		.addr (sram_addr),
		.dq   (sram_dq)
	);

	assign got_addr.raw = sram_addr;

	// 20 time unit period
	always #10 clk24 = ~clk24;

	// one xorshift round
	function automatic logic [31:0] xorshift_step(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// byte the SRAM holds at an address
	function automatic logic [7:0] expected_byte(input logic [15:0] a);
		logic [31:0] h;
		h = xorshift_step(xorshift_step(32'haa63_301d ^ {16'h0000, a}));
		return h[7:0];
	endfunction

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	//------------------------------------------------------------------
	// reference model, advanced once per rising edge
	//------------------------------------------------------------------
	task automatic model_clock();
		logic [7:0] data;
		logic       line_start;
		data = expected_byte(m_addr.raw);
		line_start = !hsync && fb_row[0];
		if (!arst_n) begin
			m_addr.raw = 16'h0000;
			m_ax = 3'd0;
			m_col = 6'd0;
			m_braw = 1'b0;
			m_load = 4'h0;
			m_bline = '0;
			for (int k = 0; k < 4; k++) begin
				m_a[k] = 8'h00;
				m_b[k] = 8'h00;
			end
		end else begin
			// idle register takes the byte, selected one shifts
			for (int k = 0; k < 4; k++) begin
				if (m_load[k] && pipe_abx)
					m_a[k] = data;
				else if (ce_pixel && !pipe_abx)
					m_a[k] = m_a[k] << 1;
				if (m_load[k] && !pipe_abx)
					m_b[k] = data;
				else if (ce_pixel && pipe_abx)
					m_b[k] = m_b[k] << 1;
			end
			if (ce_pixel)
				m_bline = {m_bline[fb_pkg::border_delay_len-2:0], m_braw};
			m_load = 4'h0;
			if (video_slice) begin
				m_addr.fields.page = 1'b1;
				m_addr.fields.plane = m_ax[2:1];
				m_addr.fields.col = m_col[5:1];
				m_addr.fields.row = fb_row[8:1];
				// strobe for plane k follows phase 2k
				if (!m_ax[0])
					m_load[m_ax[2:1]] = 1'b1;
				if (m_ax == 3'd7) begin
					if (m_col == 6'd0)
						m_braw = !m_braw;
					else if (line_start)
						m_braw = 1'b1;
					m_col = line_start ? fb_pkg::column_reload : m_col + 6'd1;
				end
				m_ax = m_ax + 3'd1;
			end
		end
	endtask

	// compare every output against the model mid-cycle
	task automatic check_outputs();
		logic [3:0] bits;
		logic       bx;
		// plane 0 lands on bit 3
		for (int k = 0; k < 4; k++)
			bits[3-k] = pipe_abx ? m_b[k][7] : m_a[k][7];
		bx = m_bline[fb_pkg::border_delay_len-1];
		compare("borderx", bx, borderx);
		compare("coloridx", bx ? border_color : bits, coloridx);
		compare("sram_addr.page", m_addr.fields.page, got_addr.fields.page);
		compare("sram_addr.plane", m_addr.fields.plane, got_addr.fields.plane);
		compare("sram_addr.col", m_addr.fields.col, got_addr.fields.col);
		compare("sram_addr.row", m_addr.fields.row, got_addr.fields.row);
	endtask

	// edge, model update, drive 2 units later, check at the falling edge
	task automatic run_cycle(input logic rst_v, input logic [28:0] s);
		@(posedge clk24);
		model_clock();
		#2;
		arst_n       = rst_v;
		video_slice  = s[28];
		ce_pixel     = s[27];
		pipe_abx     = s[26];
		hsync        = s[25];
		fb_row       = s[24:16];
		border_color = s[15:12];
		#8;
		check_outputs();
	endtask

	//------------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------------
	initial begin
		int   c;
		int   s;
		int   w;
		logic seen;
		clk24 = 1'b0;
		arst_n = 1'b0;
		ce_pixel = 1'b0;
		video_slice = 1'b0;
		pipe_abx = 1'b0;
		hsync = 1'b1;
		fb_row = 9'h000;
		border_color = 4'h0;
		n_errors = 0;
		n_checks = 0;
		seen = 1'b0;
		// fetch two columns, border flag toggles at column zero
		steps[0] = {1'b1, 1'b0, 1'b0, 1'b1, 9'h0a4, 4'h0, 12'd16};
		// line start across a phase wrap, column reloads
		steps[1] = {1'b1, 1'b0, 1'b0, 1'b0, 9'h0a5, 4'h0, 12'd8};
		// fetch and shift together until the column passes zero
		steps[2] = {1'b1, 1'b1, 1'b1, 1'b1, 9'h0a5, 4'h5, 12'd112};
		// load one full column into the idle registers
		steps[3] = {1'b1, 1'b0, 1'b0, 1'b1, 9'h0a6, 4'h3, 12'd8};
		// stall with no pixels, address holds
		steps[4] = {1'b0, 1'b0, 1'b1, 1'b1, 9'h0a6, 4'h3, 12'd3};
		// shift the column out with fetch stalled
		steps[5] = {1'b0, 1'b1, 1'b1, 1'b1, 9'h0a6, 4'h3, 12'd8};
		// reset for 10 cycles, released on the last
		for (c = 0; c < 10; c++)
			run_cycle(c == 9, {4'b0001, 9'h000, 4'h0, 12'd0});
		for (s = 0; s < 6; s++)
			for (c = 0; c < steps[s][11:0]; c++)
				run_cycle(1'b1, steps[s]);
		// run until the column wraps through zero and the border flag arrives
		for (w = 0; w < 1000 && !seen; w++) begin
			run_cycle(1'b1, {4'b1101, 9'h0a6, 4'h9, 12'd0});
			seen = borderx;
		end
		if (!seen) begin
			$display("timeout: borderx did not rise within 1000 cycles");
			n_errors++;
		end else begin
			// border colour must hold while in the border
			for (c = 0; c < 8; c++)
				run_cycle(1'b1, {4'b1101, 9'h0a6, 4'h9, 12'd0});
		end
		$display("summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- sources.f
common/fb_pkg.sv
fetch/plane_fetch.sv
shifter/plane_shifter.sv
design/pixel_out.sv
design/fb_top.sv
testbench/tb_sram_model.sv
testbench/tb_fb.sv
